//--- sources.f
+incdir+include
hw/uc_mem_pkg.sv
hw/uc_addr_decode.sv
hw/uc_msg_xbar.sv
hw/uc_cfg_regs.sv
hw/uc_clint.sv
hw/uc_mem_complex.sv
testbench/uc_mem_complex_assertions.sv
testbench/tb_uc_mem_complex.sv

//--- Makefile
# Verilator build and run for the memory complex testbench

VERILATOR ?= verilator
TOP       ?= tb_uc_mem_complex
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= *** TEST PASSED ***

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qF -- '$(PASS_TEXT)' $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- testbench/tb_uc_mem_complex.sv
`timescale 1ns/1ps

`include "uc_cfg.svh"

module tb_uc_mem_complex
  import uc_mem_pkg::*;
();

  localparam int          WAIT_LIMIT  = 200;
  localparam int          NUM_TRAFFIC = 40;
  localparam logic [63:0] IO_KEY      = 64'hC3A5_96E1_0F1E_2D3C;
  localparam logic [31:0] CFG_BASE    = 32'(`UC_CFG_DEV) << `UC_DEV_LSB;
  localparam logic [31:0] CLINT_BASE  = 32'(`UC_CLINT_DEV) << `UC_DEV_LSB;
  localparam uc_dev_id_t  CFG_ID      = uc_dev_id_t'(`DEV_CFG);
  localparam uc_dev_id_t  CLINT_ID    = uc_dev_id_t'(`DEV_CLINT);
  localparam uc_dev_id_t  IO_ID       = uc_dev_id_t'(`DEV_IO);
  localparam uc_dev_id_t  MEM_ID      = uc_dev_id_t'(`DEV_MEM);

  logic     clk_i;
  logic     rst_n_i;
  uc_cmd_s  core_cmd_i;
  logic     core_cmd_v_i;
  logic     core_cmd_ready_o;
  uc_resp_s core_resp_o;
  logic     core_resp_v_o;
  logic     core_resp_ready_i;
  uc_cmd_s  io_in_cmd_i;
  logic     io_in_cmd_v_i;
  logic     io_in_cmd_ready_o;
  uc_resp_s io_in_resp_o;
  logic     io_in_resp_v_o;
  logic     io_in_resp_ready_i;
  uc_cmd_s  io_out_cmd_o;
  logic     io_out_cmd_v_o;
  logic     io_out_cmd_ready_i;
  uc_resp_s io_out_resp_i;
  logic     io_out_resp_v_i;
  logic     io_out_resp_ready_o;
  uc_cmd_s  mem_cmd_o;
  logic     mem_cmd_v_o;
  logic     mem_cmd_ready_i;
  uc_resp_s mem_resp_i;
  logic     mem_resp_v_i;
  logic     mem_resp_ready_o;
  logic     timer_irq_o;
  logic     software_irq_o;

  integer      seed;
  uc_cmd_s     exp_cmd   [2];
  uc_dev_id_t  exp_dst   [2];
  logic        delivered [2];
  uc_resp_s    mem_pend  [$];
  uc_resp_s    io_pend   [$];
  logic [63:0] mem_store [logic [31:0]];
  logic [63:0] ref_mem   [logic [31:0]];
  logic [63:0] cfg_ref   [`UC_CFG_REGS];
  uc_cmd_s     traffic_cmd  [2][NUM_TRAFFIC];
  uc_dev_id_t  traffic_dst  [2][NUM_TRAFFIC];
  uc_resp_s    traffic_resp [2][NUM_TRAFFIC];

  uc_mem_complex dut_i (.*);

  initial
  begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("*** TEST FAILED ***");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic compare_cmd(input string name, input uc_cmd_s got, input uc_cmd_s exp);
    if (got !== exp)
    begin
      report_failure($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
    end
  endtask

  task automatic compare_resp(input string name, input uc_resp_s got, input uc_resp_s exp);
    if (got !== exp)
    begin
      report_failure($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
    end
  endtask

  task automatic compare_bit(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      report_failure($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
    end
  endtask

  // Unwritten memory reads back a pattern of the full address
  function automatic logic [63:0] mem_fill(input logic [31:0] addr);
    return {addr, ~addr};
  endfunction

  // Off-chip device behaviour, checks the delivered command first
  task automatic serve_port_cmd(input uc_dev_id_t dev, input string name, input uc_cmd_s cmd,
                                output uc_resp_s rsp);
    int src;
    src = int'(cmd.src_id);
    if (exp_dst[src] != dev || delivered[src])
    begin
      report_failure($sformatf("%s carried a command that was not expected there", name));
    end
    compare_cmd(name, cmd, exp_cmd[src]);
    delivered[src] = 1'b1;
    rsp.op     = cmd.op;
    rsp.src_id = cmd.src_id;
    if (dev == IO_ID)
    begin
      rsp.data = {32'h0, cmd.addr} ^ IO_KEY;
    end
    else if (cmd.op == UC_OP_WR)
    begin
      mem_store[cmd.addr] = cmd.data;
      rsp.data = '0;
    end
    else
    begin
      rsp.data = mem_store.exists(cmd.addr) ? mem_store[cmd.addr] : mem_fill(cmd.addr);
    end
  endtask

  always @(posedge clk_i)
  begin
    uc_resp_s rsp;
    if (rst_n_i)
    begin
      if (mem_resp_v_i && mem_resp_ready_o)
      begin
        void'(mem_pend.pop_front());
      end
      if (io_out_resp_v_i && io_out_resp_ready_o)
      begin
        void'(io_pend.pop_front());
      end
      if (mem_cmd_v_o && mem_cmd_ready_i)
      begin
        serve_port_cmd(MEM_ID, "mem_cmd_o", mem_cmd_o, rsp);
        mem_pend.push_back(rsp);
      end
      if (io_out_cmd_v_o && io_out_cmd_ready_i)
      begin
        serve_port_cmd(IO_ID, "io_out_cmd_o", io_out_cmd_o, rsp);
        io_pend.push_back(rsp);
      end
    end
  end

  // Random back-pressure and the pending off-chip responses
  always @(negedge clk_i)
  begin
    logic [31:0] rnd;
    rnd = $random(seed);
    mem_cmd_ready_i    = (rnd[1:0] != 2'b00);
    io_out_cmd_ready_i = (rnd[3:2] != 2'b00);
    core_resp_ready_i  = (rnd[5:4] != 2'b00);
    io_in_resp_ready_i = (rnd[7:6] != 2'b00);
    mem_resp_v_i       = (mem_pend.size() != 0);
    io_out_resp_v_i    = (io_pend.size() != 0);
    if (mem_pend.size() != 0)
    begin
      mem_resp_i = mem_pend[0];
    end
    if (io_pend.size() != 0)
    begin
      io_out_resp_i = io_pend[0];
    end
    if (dut_i.assertions_i.fail_count != 0)
    begin
      report_failure("a bound handshake assertion failed");
    end
  end

  // One command from a source, then its response, each with a timeout
  task automatic issue_cmd(input int src, input uc_cmd_s cmd, input uc_dev_id_t dst,
                           input uc_resp_s exp);
    int       cnt;
    logic     hs;
    uc_resp_s got;
    @(negedge clk_i);
    exp_cmd[src]        = cmd;
    exp_cmd[src].src_id = uc_src_id_t'(src);
    exp_dst[src]        = dst;
    delivered[src]      = 1'b0;
    // The decoder must overwrite this
    cmd.src_id = ~uc_src_id_t'(src);
    if (src == 0)
    begin
      core_cmd_i   = cmd;
      core_cmd_v_i = 1'b1;
    end
    else
    begin
      io_in_cmd_i   = cmd;
      io_in_cmd_v_i = 1'b1;
    end
    cnt = 0;
    hs  = 1'b0;
    while (!hs)
    begin
      @(posedge clk_i);
      hs = (src == 0) ? core_cmd_ready_o : io_in_cmd_ready_o;
      cnt++;
      if (!hs && cnt > WAIT_LIMIT)
      begin
        report_failure($sformatf("source %0d command was never accepted", src));
      end
    end
    @(negedge clk_i);
    core_cmd_v_i  = (src == 0) ? 1'b0 : core_cmd_v_i;
    io_in_cmd_v_i = (src == 1) ? 1'b0 : io_in_cmd_v_i;
    cnt = 0;
    hs  = 1'b0;
    while (!hs)
    begin
      @(posedge clk_i);
      hs  = (src == 0) ? (core_resp_v_o && core_resp_ready_i)
                       : (io_in_resp_v_o && io_in_resp_ready_i);
      got = (src == 0) ? core_resp_o : io_in_resp_o;
      cnt++;
      if (!hs && cnt > WAIT_LIMIT)
      begin
        report_failure($sformatf("source %0d response never arrived", src));
      end
    end
    compare_resp((src == 0) ? "core_resp_o" : "io_in_resp_o", got, exp);
    if ((dst == IO_ID || dst == MEM_ID) && !delivered[src])
    begin
      report_failure($sformatf("source %0d got a response before its command left", src));
    end
  endtask

  task automatic local_access(input int src, input uc_op_e op, input logic [31:0] addr,
                              input logic [63:0] data, input uc_dev_id_t dst,
                              input logic [63:0] exp_data);
    uc_cmd_s  cmd;
    uc_resp_s exp;
    cmd.op     = op;
    cmd.addr   = addr;
    cmd.src_id = '0;
    cmd.data   = data;
    exp.op     = op;
    exp.src_id = uc_src_id_t'(src);
    exp.data   = exp_data;
    issue_cmd(src, cmd, dst, exp);
  endtask

  // Mostly memory traffic in a private window per source, the rest off-chip I/O
  task automatic build_traffic();
    logic [31:0] r;
    logic [3:0]  field;
    uc_cmd_s     c;
    uc_resp_s    e;
    for (int s = 0; s < 2; s++)
    begin
      for (int i = 0; i < NUM_TRAFFIC; i++)
      begin
        r        = $random(seed);
        c.op     = r[0] ? UC_OP_WR : UC_OP_RD;
        c.src_id = '0;
        c.data   = {$random(seed), $random(seed)};
        e.op     = c.op;
        e.src_id = uc_src_id_t'(s);
        if (r[2:1] != 2'b00)
        begin
          c.addr = `UC_DRAM_BASE + 32'(s * 256) + 32'({r[15:11], 3'b000});
          traffic_dst[s][i] = MEM_ID;
          if (c.op == UC_OP_WR)
          begin
            ref_mem[c.addr] = c.data;
            e.data = '0;
          end
          else
          begin
            e.data = ref_mem.exists(c.addr) ? ref_mem[c.addr] : mem_fill(c.addr);
          end
        end
        else
        begin
          field = r[11:8];
          if (field == 4'(`UC_CFG_DEV) || field == 4'(`UC_CLINT_DEV))
          begin
            field = 4'hF;
          end
          c.addr = {1'b0, r[30:24], field, r[23:4]};
          e.data = {32'h0, c.addr} ^ IO_KEY;
          traffic_dst[s][i] = IO_ID;
        end
        traffic_cmd[s][i]  = c;
        traffic_resp[s][i] = e;
      end
    end
  endtask

  task automatic run_source(input int src);
    for (int i = 0; i < NUM_TRAFFIC; i++)
    begin
      issue_cmd(src, traffic_cmd[src][i], traffic_dst[src][i], traffic_resp[src][i]);
    end
  endtask

  task automatic wait_timer_irq(input logic level);
    int cnt;
    cnt = 0;
    while (timer_irq_o !== level && cnt < WAIT_LIMIT)
    begin
      @(posedge clk_i);
      cnt++;
    end
    compare_bit("timer_irq_o", timer_irq_o, level);
  endtask

  initial
  begin
    logic [31:0] r;
    logic [31:0] addr;
    logic [63:0] data;
    seed               = 32'h9da3b227;
    rst_n_i            = 1'b0;
    core_cmd_i         = '0;
    core_cmd_v_i       = 1'b0;
    core_resp_ready_i  = 1'b0;
    io_in_cmd_i        = '0;
    io_in_cmd_v_i      = 1'b0;
    io_in_resp_ready_i = 1'b0;
    io_out_cmd_ready_i = 1'b0;
    io_out_resp_i      = '0;
    io_out_resp_v_i    = 1'b0;
    mem_cmd_ready_i    = 1'b0;
    mem_resp_i         = '0;
    mem_resp_v_i       = 1'b0;
    delivered          = '{1'b1, 1'b1};
    exp_dst            = '{CFG_ID, CFG_ID};
    cfg_ref            = '{default: '0};
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;
    compare_bit("timer_irq_o", timer_irq_o, 1'b0);
    compare_bit("software_irq_o", software_irq_o, 1'b0);

    for (int i = 0; i < `UC_CFG_REGS; i++)
    begin
      local_access(i % 2, UC_OP_RD, CFG_BASE | 32'(i << 3), '0, CFG_ID, '0);
    end
    for (int i = 0; i < 16; i++)
    begin
      r    = $random(seed);
      addr = CFG_BASE | {12'h0, r[19:3], 3'b000};
      data = {$random(seed), $random(seed)};
      local_access(r[0], UC_OP_WR, addr, data, CFG_ID, '0);
      cfg_ref[addr[4:3]] = data;
      r    = $random(seed);
      addr = CFG_BASE | {12'h0, r[19:3], 3'b000};
      local_access(r[1], UC_OP_RD, addr, '0, CFG_ID, cfg_ref[addr[4:3]]);
    end

    local_access(0, UC_OP_RD, CLINT_BASE | 32'(`UC_MTIMECMP_OFS), '0, CLINT_ID, '1);
    local_access(1, UC_OP_WR, CLINT_BASE | 32'(`UC_MSIP_OFS), 64'h1, CLINT_ID, '0);
    compare_bit("software_irq_o", software_irq_o, 1'b1);
    local_access(0, UC_OP_RD, CLINT_BASE | 32'(`UC_MSIP_OFS), '0, CLINT_ID, 64'h1);
    local_access(0, UC_OP_WR, CLINT_BASE | 32'(`UC_MSIP_OFS), '0, CLINT_ID, '0);
    compare_bit("software_irq_o", software_irq_o, 1'b0);
    compare_bit("timer_irq_o", timer_irq_o, 1'b0);
    local_access(1, UC_OP_WR, CLINT_BASE | 32'(`UC_MTIMECMP_OFS), '0, CLINT_ID, '0);
    wait_timer_irq(1'b1);
    local_access(0, UC_OP_WR, CLINT_BASE | 32'(`UC_MTIMECMP_OFS), '1, CLINT_ID, '0);
    wait_timer_irq(1'b0);

    build_traffic();
    fork
      run_source(0);
      run_source(1);
    join

    if (dut_i.assertions_i.fail_count == 0)
    begin
      $display("*** TEST PASSED ***");
      $finish;
    end
    else
    begin
      report_failure("a bound handshake assertion failed");
    end
  end

endmodule

//--- testbench/uc_mem_complex_assertions.sv
`timescale 1ns/1ps

module uc_mem_complex_assertions
  import uc_mem_pkg::*;
(
  input logic     clk_i,
  input logic     rst_n_i,
  input uc_cmd_s  mem_cmd_o,
  input logic     mem_cmd_v_o,
  input logic     mem_cmd_ready_i,
  input uc_cmd_s  io_out_cmd_o,
  input logic     io_out_cmd_v_o,
  input logic     io_out_cmd_ready_i,
  input uc_resp_s core_resp_o,
  input logic     core_resp_v_o,
  input logic     core_resp_ready_i,
  input logic     io_in_resp_v_o
);

  int unsigned fail_count = 0;

  // A raised valid keeps its payload until the transfer
  mem_cmd_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mem_cmd_v_o && !mem_cmd_ready_i |=> mem_cmd_v_o && $stable(mem_cmd_o))
  else
  begin
    $error("mem command dropped or changed while stalled");
    fail_count++;
  end

  io_cmd_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    io_out_cmd_v_o && !io_out_cmd_ready_i |=> io_out_cmd_v_o && $stable(io_out_cmd_o))
  else
  begin
    $error("io_out command dropped or changed while stalled");
    fail_count++;
  end

  core_resp_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    core_resp_v_o && !core_resp_ready_i |=> core_resp_v_o && $stable(core_resp_o))
  else
  begin
    $error("core response dropped or changed while stalled");
    fail_count++;
  end

  // Every edge taken in reset leaves the output valids low
  reset_quiet: assert property (@(posedge clk_i)
    !rst_n_i |=> !(mem_cmd_v_o || io_out_cmd_v_o || core_resp_v_o || io_in_resp_v_o))
  else
  begin
    $error("valid output high during reset");
    fail_count++;
  end

endmodule

bind uc_mem_complex uc_mem_complex_assertions assertions_i (.*);

//--- hw/uc_mem_complex.sv
`timescale 1ns/1ps

`include "uc_cfg.svh"

module uc_mem_complex
  import uc_mem_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_n_i,

  // Core command source
  input  uc_cmd_s  core_cmd_i,
  input  logic     core_cmd_v_i,
  output logic     core_cmd_ready_o,
  output uc_resp_s core_resp_o,
  output logic     core_resp_v_o,
  input  logic     core_resp_ready_i,

  // Incoming I/O source
  input  uc_cmd_s  io_in_cmd_i,
  input  logic     io_in_cmd_v_i,
  output logic     io_in_cmd_ready_o,
  output uc_resp_s io_in_resp_o,
  output logic     io_in_resp_v_o,
  input  logic     io_in_resp_ready_i,

  // Outgoing I/O device
  output uc_cmd_s  io_out_cmd_o,
  output logic     io_out_cmd_v_o,
  input  logic     io_out_cmd_ready_i,
  input  uc_resp_s io_out_resp_i,
  input  logic     io_out_resp_v_i,
  output logic     io_out_resp_ready_o,

  // Memory device
  output uc_cmd_s  mem_cmd_o,
  output logic     mem_cmd_v_o,
  input  logic     mem_cmd_ready_i,
  input  uc_resp_s mem_resp_i,
  input  logic     mem_resp_v_i,
  output logic     mem_resp_ready_o,

  output logic     timer_irq_o,
  output logic     software_irq_o
);

  // Source side, index 0 is the core and 1 the incoming I/O
  uc_cmd_s    [`UC_NUM_SRC-1:0] src_cmd;
  uc_dev_id_t [`UC_NUM_SRC-1:0] src_dst;
  logic       [`UC_NUM_SRC-1:0] src_cmd_v;
  logic       [`UC_NUM_SRC-1:0] src_cmd_ready;
  uc_resp_s   [`UC_NUM_SRC-1:0] src_resp;
  logic       [`UC_NUM_SRC-1:0] src_resp_v;
  logic       [`UC_NUM_SRC-1:0] src_resp_ready;

  uc_cmd_s    [`UC_NUM_DEV-1:0] dev_cmd;
  logic       [`UC_NUM_DEV-1:0] dev_cmd_v;
  logic       [`UC_NUM_DEV-1:0] dev_cmd_ready;
  uc_resp_s   [`UC_NUM_DEV-1:0] dev_resp;
  uc_src_id_t [`UC_NUM_DEV-1:0] dev_resp_dst;
  logic       [`UC_NUM_DEV-1:0] dev_resp_v;
  logic       [`UC_NUM_DEV-1:0] dev_resp_ready;

  uc_addr_decode #(.SRC_ID(0)) core_decode
  (
    .cmd_i (core_cmd_i),
    .cmd_o (src_cmd[0]),
    .dst_o (src_dst[0])
  );

  uc_addr_decode #(.SRC_ID(1)) io_in_decode
  (
    .cmd_i (io_in_cmd_i),
    .cmd_o (src_cmd[1]),
    .dst_o (src_dst[1])
  );

  assign src_cmd_v         = {io_in_cmd_v_i, core_cmd_v_i};
  assign core_cmd_ready_o  = src_cmd_ready[0];
  assign io_in_cmd_ready_o = src_cmd_ready[1];

  assign core_resp_o    = src_resp[0];
  assign core_resp_v_o  = src_resp_v[0];
  assign io_in_resp_o   = src_resp[1];
  assign io_in_resp_v_o = src_resp_v[1];
  assign src_resp_ready = {io_in_resp_ready_i, core_resp_ready_i};

  // Off-chip devices sit on the last two crossbar ports
  assign io_out_cmd_o              = dev_cmd[`DEV_IO];
  assign io_out_cmd_v_o            = dev_cmd_v[`DEV_IO];
  assign dev_cmd_ready[`DEV_IO]    = io_out_cmd_ready_i;
  assign dev_resp[`DEV_IO]         = io_out_resp_i;
  assign dev_resp_v[`DEV_IO]       = io_out_resp_v_i;
  assign io_out_resp_ready_o       = dev_resp_ready[`DEV_IO];

  assign mem_cmd_o                 = dev_cmd[`DEV_MEM];
  assign mem_cmd_v_o               = dev_cmd_v[`DEV_MEM];
  assign dev_cmd_ready[`DEV_MEM]   = mem_cmd_ready_i;
  assign dev_resp[`DEV_MEM]        = mem_resp_i;
  assign dev_resp_v[`DEV_MEM]      = mem_resp_v_i;
  assign mem_resp_ready_o          = dev_resp_ready[`DEV_MEM];

  for (genvar d = 0; d < `UC_NUM_DEV; d++)
  begin : g_resp_dst
    assign dev_resp_dst[d] = dev_resp[d].src_id;
  end

  uc_msg_xbar #(.msg_t(uc_cmd_s), .NUM_IN(`UC_NUM_SRC), .NUM_OUT(`UC_NUM_DEV)) cmd_xbar
  (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .in_msg_i    (src_cmd),
    .in_v_i      (src_cmd_v),
    .in_dst_i    (src_dst),
    .in_ready_o  (src_cmd_ready),
    .out_msg_o   (dev_cmd),
    .out_v_o     (dev_cmd_v),
    .out_ready_i (dev_cmd_ready)
  );

  uc_msg_xbar #(.msg_t(uc_resp_s), .NUM_IN(`UC_NUM_DEV), .NUM_OUT(`UC_NUM_SRC)) resp_xbar
  (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .in_msg_i    (dev_resp),
    .in_v_i      (dev_resp_v),
    .in_dst_i    (dev_resp_dst),
    .in_ready_o  (dev_resp_ready),
    .out_msg_o   (src_resp),
    .out_v_o     (src_resp_v),
    .out_ready_i (src_resp_ready)
  );

  uc_cfg_regs cfg
  (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .cmd_i        (dev_cmd[`DEV_CFG]),
    .cmd_v_i      (dev_cmd_v[`DEV_CFG]),
    .cmd_ready_o  (dev_cmd_ready[`DEV_CFG]),
    .resp_o       (dev_resp[`DEV_CFG]),
    .resp_v_o     (dev_resp_v[`DEV_CFG]),
    .resp_ready_i (dev_resp_ready[`DEV_CFG])
  );

  uc_clint clint
  (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .cmd_i          (dev_cmd[`DEV_CLINT]),
    .cmd_v_i        (dev_cmd_v[`DEV_CLINT]),
    .cmd_ready_o    (dev_cmd_ready[`DEV_CLINT]),
    .resp_o         (dev_resp[`DEV_CLINT]),
    .resp_v_o       (dev_resp_v[`DEV_CLINT]),
    .resp_ready_i   (dev_resp_ready[`DEV_CLINT]),
    .timer_irq_o    (timer_irq_o),
    .software_irq_o (software_irq_o)
  );

endmodule

//--- hw/uc_clint.sv
`timescale 1ns/1ps

`include "uc_cfg.svh"

module uc_clint
  import uc_mem_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_n_i,

  input  uc_cmd_s  cmd_i,
  input  logic     cmd_v_i,
  output logic     cmd_ready_o,

  output uc_resp_s resp_o,
  output logic     resp_v_o,
  input  logic     resp_ready_i,

  output logic     timer_irq_o,
  output logic     software_irq_o
);

  logic [`UC_DATA_W-1:0] mtime_q;
  logic [`UC_DATA_W-1:0] mtimecmp_q;
  logic                  msip_q;
  logic                  timer_irq_q;
  logic [15:0]           ofs;
  logic                  accept;
  logic                  is_wr;
  logic                  wr;
  logic [`UC_DATA_W-1:0] rd_data;
  logic                  resp_v_q;
  uc_resp_s              resp_q;

  assign ofs         = cmd_i.addr[15:0];
  assign is_wr       = (cmd_i.op == UC_OP_WR);
  assign cmd_ready_o = ~resp_v_q | resp_ready_i;
  assign accept      = cmd_v_i & cmd_ready_o;
  assign wr          = accept & is_wr;

  always_comb
  begin
    rd_data = '0;
    case (ofs)
      `UC_MSIP_OFS:     rd_data[0] = msip_q;
      `UC_MTIMECMP_OFS: rd_data    = mtimecmp_q;
      `UC_MTIME_OFS:    rd_data    = mtime_q;
      default:          rd_data    = '0;
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      mtime_q     <= '0;
      mtimecmp_q  <= '1;
      msip_q      <= 1'b0;
      timer_irq_q <= 1'b0;
    end
    else
    begin
      timer_irq_q <= (mtime_q >= mtimecmp_q);
      // A write to mtime takes the place of this cycle's tick
      if (wr && (ofs == `UC_MTIME_OFS))
      begin
        mtime_q <= cmd_i.data;
      end
      else
      begin
        mtime_q <= mtime_q + 1'b1;
      end
      if (wr && (ofs == `UC_MTIMECMP_OFS))
      begin
        mtimecmp_q <= cmd_i.data;
      end
      if (wr && (ofs == `UC_MSIP_OFS))
      begin
        msip_q <= cmd_i.data[0];
      end
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      resp_v_q <= 1'b0;
    end
    else if (accept)
    begin
      resp_v_q <= 1'b1;
    end
    else if (resp_ready_i)
    begin
      resp_v_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (accept)
    begin
      resp_q.op     <= cmd_i.op;
      resp_q.src_id <= cmd_i.src_id;
      resp_q.data   <= is_wr ? '0 : rd_data;
    end
  end

  assign resp_o         = resp_q;
  assign resp_v_o       = resp_v_q;
  assign timer_irq_o    = timer_irq_q;
  assign software_irq_o = msip_q;

endmodule

//--- hw/uc_cfg_regs.sv
`timescale 1ns/1ps

`include "uc_cfg.svh"

module uc_cfg_regs
  import uc_mem_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_n_i,

  input  uc_cmd_s  cmd_i,
  input  logic     cmd_v_i,
  output logic     cmd_ready_o,

  output uc_resp_s resp_o,
  output logic     resp_v_o,
  input  logic     resp_ready_i
);

  localparam int IDX_W = $clog2(`UC_CFG_REGS);

  logic [`UC_CFG_REGS-1:0][`UC_DATA_W-1:0] regs_q;
  logic [IDX_W-1:0]                        idx;
  logic                                    accept;
  logic                                    is_wr;
  logic                                    resp_v_q;
  uc_resp_s                                resp_q;

  // Doubleword registers, upper offset bits wrap
  assign idx         = cmd_i.addr[3 +: IDX_W];
  assign is_wr       = (cmd_i.op == UC_OP_WR);
  assign cmd_ready_o = ~resp_v_q | resp_ready_i;
  assign accept      = cmd_v_i & cmd_ready_o;

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      regs_q   <= '0;
      resp_v_q <= 1'b0;
    end
    else if (accept)
    begin
      resp_v_q <= 1'b1;
      if (is_wr)
      begin
        regs_q[idx] <= cmd_i.data;
      end
    end
    else if (resp_ready_i)
    begin
      resp_v_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (accept)
    begin
      resp_q.op     <= cmd_i.op;
      resp_q.src_id <= cmd_i.src_id;
      resp_q.data   <= is_wr ? '0 : regs_q[idx];
    end
  end

  assign resp_o   = resp_q;
  assign resp_v_o = resp_v_q;

endmodule

//--- hw/uc_msg_xbar.sv
`timescale 1ns/1ps

module uc_msg_xbar
  import uc_mem_pkg::*;
#(
  parameter type msg_t   = uc_cmd_s,
  parameter int  NUM_IN  = 2,
  parameter int  NUM_OUT = 4,
  localparam int IN_W    = (NUM_IN > 1) ? $clog2(NUM_IN) : 1,
  localparam int DST_W   = (NUM_OUT > 1) ? $clog2(NUM_OUT) : 1
)
(
  input  logic                         clk_i,
  input  logic                         rst_n_i,

  input  msg_t [NUM_IN-1:0]            in_msg_i,
  input  logic [NUM_IN-1:0]            in_v_i,
  input  logic [NUM_IN-1:0][DST_W-1:0] in_dst_i,
  output logic [NUM_IN-1:0]            in_ready_o,

  output msg_t [NUM_OUT-1:0]           out_msg_o,
  output logic [NUM_OUT-1:0]           out_v_o,
  input  logic [NUM_OUT-1:0]           out_ready_i
);

  // One-hot grant of each sink over the inputs
  logic [NUM_OUT-1:0][NUM_IN-1:0] grant;

  for (genvar o = 0; o < NUM_OUT; o++)
  begin : g_sink
    logic [IN_W-1:0]   ptr_q;
    logic [NUM_IN-1:0] req;
    logic [IN_W-1:0]   win_idx;
    logic              win_found;
    logic              load_ok;
    logic              take;
    logic              out_v_q;
    msg_t              out_msg_q;

    // Empty or draining this cycle
    assign load_ok = ~out_v_q | out_ready_i[o];

    always_comb
    begin
      for (int i = 0; i < NUM_IN; i++)
      begin
        req[i] = in_v_i[i] && (in_dst_i[i] == DST_W'(o));
      end
    end

    // Search starts at the pointer and wraps
    always_comb
    begin
      int idx;
      win_found = 1'b0;
      win_idx   = '0;
      for (int k = 0; k < NUM_IN; k++)
      begin
        idx = (int'(ptr_q) + k) % NUM_IN;
        if (!win_found && req[idx])
        begin
          win_found = 1'b1;
          win_idx   = IN_W'(idx);
        end
      end
    end

    assign take     = win_found & load_ok;
    assign grant[o] = take ? (NUM_IN'(1) << win_idx) : '0;

    always_ff @(posedge clk_i)
    begin
      if (!rst_n_i)
      begin
        out_v_q <= 1'b0;
        ptr_q   <= '0;
      end
      else if (take)
      begin
        out_v_q <= 1'b1;
        // winner gets lowest priority next time
        ptr_q   <= (win_idx == IN_W'(NUM_IN - 1)) ? '0 : win_idx + 1'b1;
      end
      else if (out_ready_i[o])
      begin
        out_v_q <= 1'b0;
      end
    end

    always_ff @(posedge clk_i)
    begin
      if (take)
      begin
        out_msg_q <= in_msg_i[win_idx];
      end
    end

    assign out_v_o[o]   = out_v_q;
    assign out_msg_o[o] = out_msg_q;
  end

  // An input targets one sink, so at most one grant column is set
  always_comb
  begin
    in_ready_o = '0;
    for (int o = 0; o < NUM_OUT; o++)
    begin
      in_ready_o = in_ready_o | grant[o];
    end
  end

endmodule

//--- hw/uc_addr_decode.sv
`timescale 1ns/1ps

`include "uc_cfg.svh"

module uc_addr_decode
  import uc_mem_pkg::*;
#(
  parameter int SRC_ID = 0
)
(
  input  uc_cmd_s    cmd_i,
  output uc_cmd_s    cmd_o,
  output uc_dev_id_t dst_o
);

  localparam int DEV_W = `UC_DEV_MSB - `UC_DEV_LSB + 1;

  logic [DEV_W-1:0] dev_field;
  logic             is_dram;

  assign dev_field = cmd_i.addr[`UC_DEV_MSB:`UC_DEV_LSB];
  assign is_dram   = (cmd_i.addr >= `UC_DRAM_BASE);

  // Stamp the port index so the response finds its way back
  always_comb
  begin
    cmd_o        = cmd_i;
    cmd_o.src_id = uc_src_id_t'(SRC_ID);
  end

  always_comb
  begin
    if (is_dram)
    begin
      dst_o = uc_dev_id_t'(`DEV_MEM);
    end
    else if (dev_field == DEV_W'(`UC_CFG_DEV))
    begin
      dst_o = uc_dev_id_t'(`DEV_CFG);
    end
    else if (dev_field == DEV_W'(`UC_CLINT_DEV))
    begin
      dst_o = uc_dev_id_t'(`DEV_CLINT);
    end
    else
    begin
      // Everything else local is handled off chip
      dst_o = uc_dev_id_t'(`DEV_IO);
    end
  end

endmodule

//--- hw/uc_mem_pkg.sv
`include "uc_cfg.svh"

package uc_mem_pkg;

  typedef enum logic
  {
    UC_OP_RD = 1'b0,
    UC_OP_WR = 1'b1
  } uc_op_e;

  // Index of the issuing source, carried back on the response
  typedef logic [$clog2(`UC_NUM_SRC)-1:0] uc_src_id_t;

  typedef logic [$clog2(`UC_NUM_DEV)-1:0] uc_dev_id_t;

  typedef struct packed
  {
    uc_op_e                op;
    logic [`UC_ADDR_W-1:0] addr;
    uc_src_id_t            src_id;
    logic [`UC_DATA_W-1:0] data;
  } uc_cmd_s;

  // Responses have no address, the source id routes them
  typedef struct packed
  {
    uc_op_e                op;
    uc_src_id_t            src_id;
    logic [`UC_DATA_W-1:0] data;
  } uc_resp_s;

endpackage

//--- include/uc_cfg.svh
`ifndef UC_CFG_SVH
`define UC_CFG_SVH

// Bus widths
`define UC_ADDR_W 32
`define UC_DATA_W 64

// Port counts on the two crossbars
`define UC_NUM_SRC 2
`define UC_NUM_DEV 4

// Physical address map
`define UC_DRAM_BASE 32'h8000_0000
`define UC_DEV_MSB   23
`define UC_DEV_LSB   20
`define UC_CFG_DEV   1
`define UC_CLINT_DEV 2

`define UC_CFG_REGS 4

// CLINT register offsets inside its device window
`define UC_MSIP_OFS     16'h0000
`define UC_MTIMECMP_OFS 16'h4000
`define UC_MTIME_OFS    16'hBFF8

// Sink index of each device on the command crossbar
`define DEV_CFG   0
`define DEV_CLINT 1
`define DEV_IO    2
`define DEV_MEM   3

`endif
